/* Bender.yml */
package:
  name: simd_exec_unit

sources:
  # packages first, then the design bottom up
  - files:
      - hdl/simd_types_pkg.sv
      - hdl/simd_csr_pkg.sv
      - hdl/operand_stage.sv
      - hdl/simd_alu.sv
      - hdl/simd_csr.sv
      - hdl/simd_exec_unit.sv

  # testbench, top module simd_exec_unit_tb
  - target: test
    files:
      - tests/simd_exec_unit_properties.sv
      - tests/simd_exec_unit_tb.sv

/* filelist.f */
hdl/simd_types_pkg.sv
hdl/simd_csr_pkg.sv
hdl/operand_stage.sv
hdl/simd_alu.sv
hdl/simd_csr.sv
hdl/simd_exec_unit.sv
tests/simd_exec_unit_properties.sv
tests/simd_exec_unit_tb.sv

/* hdl/operand_stage.sv */
// ######################################
// operand forwarding and the registered operand stage
// picks port, current or previous bus value per source
// ######################################

`default_nettype none

module operand_stage #(
  parameter int NUM_FWD = 3
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     issue_valid,
  input  simd_types_pkg::opcode_e                  issue_op,
  input  simd_types_pkg::lane_sz_e                 issue_lane_sz,
  input  simd_types_pkg::data_t                    src_a,
  input  simd_types_pkg::data_t                    src_b,
  input  simd_types_pkg::data_t [NUM_FWD-1:0]      fwd_bus,
  input  logic [NUM_FWD-1:0]                       fwd_now_a,
  input  logic [NUM_FWD-1:0]                       fwd_prev_a,
  input  logic [NUM_FWD-1:0]                       fwd_now_b,
  input  logic [NUM_FWD-1:0]                       fwd_prev_b,
  output logic                                     ex_valid,
  output simd_types_pkg::opcode_e                  ex_op,
  output simd_types_pkg::lane_sz_e                 ex_lane_sz,
  output simd_types_pkg::data_t                    ex_a,
  output simd_types_pkg::data_t                    ex_b
);

  simd_types_pkg::data_t [NUM_FWD-1:0] fwd_q; // bus values one cycle back
  simd_types_pkg::data_t opa;
  simd_types_pkg::data_t opb;

  // selects are one-hot or zero, so loop order does not matter
  function automatic simd_types_pkg::data_t pick_operand(
    input simd_types_pkg::data_t               port_val,
    input logic [NUM_FWD-1:0]                  now_sel,
    input logic [NUM_FWD-1:0]                  prev_sel,
    input simd_types_pkg::data_t [NUM_FWD-1:0] now_val,
    input simd_types_pkg::data_t [NUM_FWD-1:0] prev_val
  );
    simd_types_pkg::data_t v;
    v = port_val;
    for (int i = 0; i < NUM_FWD; i++) begin
      if (now_sel[i]) v = now_val[i];
      if (prev_sel[i]) v = prev_val[i];
    end
    return v;
  endfunction

  assign opa = pick_operand(src_a, fwd_now_a, fwd_prev_a, fwd_bus, fwd_q);
  assign opb = pick_operand(src_b, fwd_now_b, fwd_prev_b, fwd_bus, fwd_q);

  always_ff @(posedge clk) begin
    fwd_q <= fwd_bus;
  end

  always_ff @(posedge clk) begin
    ex_op      <= issue_op;
    ex_lane_sz <= issue_lane_sz;
    ex_a       <= opa;
    ex_b       <= opb;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= issue_valid;
    end
  end

endmodule

`default_nettype wire

/* hdl/simd_alu.sv */
// ######################################
// lane-split integer execute stage
// one shared chunk adder serves add, sub and compares;
// result and masked causes leave one cycle after ex_*
// ######################################

`default_nettype none

module simd_alu (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ex_valid,
  input  simd_types_pkg::opcode_e  ex_op,
  input  simd_types_pkg::lane_sz_e ex_lane_sz,
  input  simd_types_pkg::data_t    ex_a,
  input  simd_types_pkg::data_t    ex_b,
  input  simd_types_pkg::cause_t   excpt_en,
  output simd_types_pkg::data_t    result,
  output logic                     result_valid,
  output logic                     ret_valid,
  output simd_types_pkg::cause_t   ret_code,
  output simd_types_pkg::cause_t   raise
);

  localparam int LW = simd_types_pkg::LANE_W;
  localparam int NCH = simd_types_pkg::DATA_W / LW;

  logic [NCH-1:0] chunk_first;
  logic [NCH-1:0] chunk_last;
  logic [NCH-1:0] chunk_ovf;
  logic [NCH-1:0] lane_true; // compare outcome, valid at top chunk of a lane
  logic is_sub;
  logic is_gt;
  simd_types_pkg::data_t add_x;
  simd_types_pkg::data_t add_y;
  simd_types_pkg::data_t sum;
  simd_types_pkg::data_t cmp_mask;
  simd_types_pkg::data_t res_d;
  simd_types_pkg::cause_t cause_d;

  always_comb begin
    for (int i = 0; i < NCH; i++) begin
      case (ex_lane_sz)
        simd_types_pkg::lane_16: begin
          chunk_first[i] = 1'b1;
          chunk_last[i]  = 1'b1;
        end
        simd_types_pkg::lane_32: begin
          chunk_first[i] = (i % 2) == 0;
          chunk_last[i]  = (i % 2) == 1;
        end
        default: begin
          chunk_first[i] = i == 0;
          chunk_last[i]  = i == NCH - 1;
        end
      endcase
    end
  end

  // a > b is taken from the sign of b - a
  assign is_gt = ex_op == simd_types_pkg::op_cmpgt;
  assign is_sub = ex_op != simd_types_pkg::op_add;
  assign add_x = is_gt ? ex_b : ex_a;
  assign add_y = (is_gt ? ex_a : ex_b) ^ {simd_types_pkg::DATA_W{is_sub}};

  // carry chain cut at every lane start
  always_comb begin
    logic carry;
    logic zero_acc;
    logic [LW:0] part;
    carry = 1'b0;
    zero_acc = 1'b1;
    sum = '0;
    chunk_ovf = '0;
    lane_true = '0;
    for (int i = 0; i < NCH; i++) begin
      if (chunk_first[i]) begin
        carry = is_sub;
        zero_acc = 1'b1;
      end
      part = {1'b0, add_x[i*LW +: LW]} + {1'b0, add_y[i*LW +: LW]} + {{LW{1'b0}}, carry};
      sum[i*LW +: LW] = part[LW-1:0];
      carry = part[LW];
      zero_acc = zero_acc & (part[LW-1:0] == '0);
      chunk_ovf[i] = (add_x[i*LW+LW-1] == add_y[i*LW+LW-1]) &&
                     (part[LW-1] != add_x[i*LW+LW-1]);
      if (chunk_last[i]) lane_true[i] = is_gt ? (part[LW-1] ^ chunk_ovf[i]) : zero_acc;
    end
  end

  // walk down from the top so each lane's flag fills its lower chunks
  always_comb begin
    logic flag;
    flag = 1'b0;
    for (int i = NCH - 1; i >= 0; i--) begin
      if (chunk_last[i]) flag = lane_true[i];
      cmp_mask[i*LW +: LW] = {LW{flag}};
    end
  end

  always_comb begin
    res_d = '0;
    cause_d = '0;
    case (ex_op)
      simd_types_pkg::op_add, simd_types_pkg::op_sub: begin
        res_d = sum;
        cause_d[simd_types_pkg::CAUSE_OVF] = |(chunk_ovf & chunk_last);
      end
      simd_types_pkg::op_and: res_d = ex_a & ex_b;
      simd_types_pkg::op_or: res_d = ex_a | ex_b;
      simd_types_pkg::op_xor: res_d = ex_a ^ ex_b;
      simd_types_pkg::op_cmpeq, simd_types_pkg::op_cmpgt: res_d = cmp_mask;
      default: cause_d[simd_types_pkg::CAUSE_ILL] = 1'b1; // zero result
    endcase
  end

  always_ff @(posedge clk) begin
    result <= res_d;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      ret_valid    <= 1'b0;
      ret_code     <= '0;
      raise        <= '0;
    end else begin
      result_valid <= ex_valid;
      raise        <= ex_valid ? cause_d : '0;
      ret_code     <= ex_valid ? (cause_d & excpt_en) : '0;
      ret_valid    <= ex_valid && |(cause_d & excpt_en);
    end
  end

endmodule

`default_nettype wire

/* hdl/simd_csr.sv */
// ######################################
// APB register block, no wait states
// CTRL holds exception enables, STATUS the sticky causes
// ######################################

`default_nettype none

module simd_csr (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  simd_csr_pkg::apb_addr_t paddr,
  input  simd_csr_pkg::apb_data_t pwdata,
  input  simd_types_pkg::cause_t  raise,
  output simd_csr_pkg::apb_data_t prdata,
  output logic                    pready,
  output logic                    pslverr,
  output simd_types_pkg::cause_t  excpt_en
);

  logic access;
  logic hit;
  logic wr_ctrl;
  logic wr_status;
  simd_types_pkg::cause_t status_q;
  simd_types_pkg::cause_t status_clr;

  assign access = psel & penable;
  assign hit = (paddr == simd_csr_pkg::CTRL_ADDR) || (paddr == simd_csr_pkg::STATUS_ADDR);
  assign wr_ctrl = access & pwrite & (paddr == simd_csr_pkg::CTRL_ADDR);
  assign wr_status = access & pwrite & (paddr == simd_csr_pkg::STATUS_ADDR);
  assign status_clr = wr_status ? pwdata[simd_csr_pkg::EXCPT_W-1:0] : '0;

  assign pready = access;
  assign pslverr = access & ~hit;

  always_comb begin
    prdata = '0; // unmapped reads zero
    case (paddr)
      simd_csr_pkg::CTRL_ADDR: begin
        prdata[simd_csr_pkg::EXCPT_W-1:0] = excpt_en;
      end
      simd_csr_pkg::STATUS_ADDR: begin
        prdata[simd_csr_pkg::EXCPT_W-1:0] = status_q;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      excpt_en <= '0;
    end else if (wr_ctrl) begin
      excpt_en <= pwdata[simd_csr_pkg::EXCPT_W-1:0];
    end
  end

  // new raise beats a same-cycle clear
  always_ff @(posedge clk) begin
    if (rst) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clr) | raise;
    end
  end

endmodule

`default_nettype wire

/* hdl/simd_csr_pkg.sv */
// ######################################
// APB register map of the SIMD unit
// addresses and field widths for the register block
// ######################################

`default_nettype none

package simd_csr_pkg;

  localparam int ADDR_W = 8;
  localparam int PDATA_W = 32;
  localparam int EXCPT_W = 2; // enable and status fields

  typedef logic [ADDR_W-1:0] apb_addr_t;
  typedef logic [PDATA_W-1:0] apb_data_t;

  localparam apb_addr_t CTRL_ADDR = 8'h00;   // exception enable
  localparam apb_addr_t STATUS_ADDR = 8'h04; // sticky causes, w1c

endpackage

`default_nettype wire

/* hdl/simd_exec_unit.sv */
// ######################################
// top of the SIMD integer execution unit
// issue to result in 2 cycles, registers over APB
// ######################################

`default_nettype none

module simd_exec_unit #(
  parameter int NUM_FWD = 3
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                issue_valid,
  input  simd_types_pkg::opcode_e             issue_op,
  input  simd_types_pkg::lane_sz_e            issue_lane_sz,
  input  simd_types_pkg::data_t               src_a,
  input  simd_types_pkg::data_t               src_b,
  input  simd_types_pkg::data_t [NUM_FWD-1:0] fwd_bus,
  input  logic [NUM_FWD-1:0]                  fwd_now_a,
  input  logic [NUM_FWD-1:0]                  fwd_prev_a,
  input  logic [NUM_FWD-1:0]                  fwd_now_b,
  input  logic [NUM_FWD-1:0]                  fwd_prev_b,
  output simd_types_pkg::data_t               result,
  output logic                                result_valid,
  output logic                                ret_valid,
  output simd_types_pkg::cause_t              ret_code,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  simd_csr_pkg::apb_addr_t             paddr,
  input  simd_csr_pkg::apb_data_t             pwdata,
  output simd_csr_pkg::apb_data_t             prdata,
  output logic                                pready,
  output logic                                pslverr
);

  logic ex_valid;
  simd_types_pkg::opcode_e ex_op;
  simd_types_pkg::lane_sz_e ex_lane_sz;
  simd_types_pkg::data_t ex_a;
  simd_types_pkg::data_t ex_b;
  simd_types_pkg::cause_t raise;    // unmasked, to sticky status
  simd_types_pkg::cause_t excpt_en;

  operand_stage #(.NUM_FWD(NUM_FWD)) operand_stage_i (
    .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_op(issue_op),
    .issue_lane_sz(issue_lane_sz), .src_a(src_a), .src_b(src_b), .fwd_bus(fwd_bus),
    .fwd_now_a(fwd_now_a), .fwd_prev_a(fwd_prev_a),
    .fwd_now_b(fwd_now_b), .fwd_prev_b(fwd_prev_b),
    .ex_valid(ex_valid), .ex_op(ex_op), .ex_lane_sz(ex_lane_sz), .ex_a(ex_a), .ex_b(ex_b)
  );

  simd_alu simd_alu_i (
    .clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_op(ex_op), .ex_lane_sz(ex_lane_sz),
    .ex_a(ex_a), .ex_b(ex_b), .excpt_en(excpt_en), .result(result),
    .result_valid(result_valid), .ret_valid(ret_valid), .ret_code(ret_code), .raise(raise)
  );

  simd_csr simd_csr_i (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .raise(raise), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .excpt_en(excpt_en)
  );

endmodule

`default_nettype wire

/* hdl/simd_types_pkg.sv */
// ######################################
// datapath types for the packed SIMD integer unit
// shared by the operand stage, the ALU and the top level
// ######################################

`default_nettype none

package simd_types_pkg;

  localparam int DATA_W = 64;
  localparam int LANE_W = 16; // smallest lane, also the ALU chunk size

  typedef logic [DATA_W-1:0] data_t;

  typedef enum logic [2:0] {
    op_add     = 3'd0,
    op_sub     = 3'd1,
    op_and     = 3'd2,
    op_or      = 3'd3,
    op_xor     = 3'd4,
    op_cmpeq   = 3'd5,
    op_cmpgt   = 3'd6,
    op_illegal = 3'd7
  } opcode_e;

  // code 3 is executed as lane_64
  typedef enum logic [1:0] {
    lane_16 = 2'd0,
    lane_32 = 2'd1,
    lane_64 = 2'd2
  } lane_sz_e;

  localparam int CAUSE_W = 2;
  typedef logic [CAUSE_W-1:0] cause_t;

  localparam int CAUSE_OVF = 0; // signed overflow in any lane
  localparam int CAUSE_ILL = 1; // illegal opcode

endpackage

`default_nettype wire

/* tests/simd_exec_unit_properties.sv */
// ######################################
// concurrent checks on the SIMD unit, bound into
// simd_exec_unit from the testbench
// ######################################

`default_nettype none

module simd_exec_unit_properties (
  input logic                   clk,
  input logic                   rst,
  input logic                   ex_valid,
  input logic                   result_valid,
  input logic                   ret_valid,
  input simd_types_pkg::cause_t ret_code,
  input simd_types_pkg::cause_t excpt_en,
  input logic                   psel,
  input logic                   penable,
  input logic                   pready,
  input logic                   pslverr
);

  int fail_cnt = 0;

  ret_needs_result: assert property (
    @(posedge clk) disable iff (rst) ret_valid |-> result_valid
  ) else begin
    fail_cnt++;
    $error("ret_valid high without result_valid");
  end

  // no wait states
  pready_access: assert property (@(posedge clk) pready == (psel && penable))
    else begin
      fail_cnt++;
      $error("pready does not match the APB access phase");
    end

  quiet_after_reset: assert property (
    @(posedge clk) rst |=> !ex_valid && !result_valid && !ret_valid && !pslverr &&
                           ret_code == '0 && excpt_en == '0
  ) else begin
    fail_cnt++;
    $error("outputs active right after reset");
  end

endmodule

`default_nettype wire

/* tests/simd_exec_unit_tb.sv */
// ######################################
// testbench for the SIMD integer execution unit
// random issue stream checked against a lane-wise model,
// APB register checks; run as top module simd_exec_unit_tb
// ######################################

`default_nettype none

module simd_exec_unit_tb;

  localparam int NUM_FWD = 3;
  localparam int N_OPS = 40;
  // 5 issue phases, up to 4 cycles per op, doubled, plus APB traffic
  localparam int MAX_CYCLES = 5 * N_OPS * 4 * 2 + 400;

  typedef simd_types_pkg::data_t [NUM_FWD-1:0] fwd_t;
  typedef struct {
    int                     due;
    simd_types_pkg::data_t  res;
    simd_types_pkg::cause_t cause;
  } exp_t;

  logic clk;
  logic rst;
  logic issue_valid;
  simd_types_pkg::opcode_e issue_op;
  simd_types_pkg::lane_sz_e issue_lane_sz;
  simd_types_pkg::data_t src_a;
  simd_types_pkg::data_t src_b;
  fwd_t fwd_bus;
  logic [NUM_FWD-1:0] fwd_now_a;
  logic [NUM_FWD-1:0] fwd_prev_a;
  logic [NUM_FWD-1:0] fwd_now_b;
  logic [NUM_FWD-1:0] fwd_prev_b;
  simd_types_pkg::data_t result;
  logic result_valid;
  logic ret_valid;
  simd_types_pkg::cause_t ret_code;
  logic psel;
  logic penable;
  logic pwrite;
  simd_csr_pkg::apb_addr_t paddr;
  simd_csr_pkg::apb_data_t pwdata;
  simd_csr_pkg::apb_data_t prdata;
  logic pready;
  logic pslverr;

  integer seed = 32'hb47c;
  int cyc = 0;
  int checks = 0;
  int errors = 0;
  int test_no = 0;
  int checks_at = 0;
  int errors_at = 0;
  exp_t exp_q[$];
  fwd_t fwd_prev;                    // bus values seen one cycle back
  simd_types_pkg::cause_t en_pend;   // enable as the DUT holds it now
  simd_types_pkg::cause_t en_last;   // enable one cycle back
  simd_types_pkg::cause_t raise_acc = '0;

  simd_exec_unit #(.NUM_FWD(NUM_FWD)) simd_exec_unit_i (
    .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_op(issue_op),
    .issue_lane_sz(issue_lane_sz), .src_a(src_a), .src_b(src_b), .fwd_bus(fwd_bus),
    .fwd_now_a(fwd_now_a), .fwd_prev_a(fwd_prev_a),
    .fwd_now_b(fwd_now_b), .fwd_prev_b(fwd_prev_b),
    .result(result), .result_valid(result_valid), .ret_valid(ret_valid), .ret_code(ret_code),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  bind simd_exec_unit simd_exec_unit_properties props_i (
    .clk(clk), .rst(rst), .ex_valid(ex_valid), .result_valid(result_valid),
    .ret_valid(ret_valid), .ret_code(ret_code), .excpt_en(excpt_en),
    .psel(psel), .penable(penable), .pready(pready), .pslverr(pslverr)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [65:0] sign_ext(input logic [63:0] v, input int w);
    logic [65:0] r;
    r = {2'b00, v};
    for (int i = w; i < 66; i++) r[i] = v[w-1];
    return r;
  endfunction

  // lane-wise reference, one lane at a time in wide signed arithmetic
  function automatic void model_exec(
    input simd_types_pkg::opcode_e  op,
    input simd_types_pkg::lane_sz_e lsz,
    input simd_types_pkg::data_t    a,
    input simd_types_pkg::data_t    b,
    output simd_types_pkg::data_t   res,
    output simd_types_pkg::cause_t  cause
  );
    int w;
    logic [63:0] mask;
    logic [65:0] xa;
    logic [65:0] xb;
    logic [65:0] s;
    res = '0;
    cause = '0;
    w = (lsz == simd_types_pkg::lane_16) ? 16 : (lsz == simd_types_pkg::lane_32) ? 32 : 64;
    mask = {64{1'b1}} >> (64 - w);
    case (op)
      simd_types_pkg::op_and: res = a & b;
      simd_types_pkg::op_or: res = a | b;
      simd_types_pkg::op_xor: res = a ^ b;
      simd_types_pkg::op_illegal: cause[simd_types_pkg::CAUSE_ILL] = 1'b1;
      default: begin
        for (int k = 0; k < 64 / w; k++) begin
          xa = sign_ext((a >> (k * w)) & mask, w);
          xb = sign_ext((b >> (k * w)) & mask, w);
          case (op)
            simd_types_pkg::op_add: s = xa + xb;
            simd_types_pkg::op_sub: s = xa - xb;
            simd_types_pkg::op_cmpeq: s = (xa == xb) ? '1 : '0;
            default: s = ($signed(xa) > $signed(xb)) ? '1 : '0;
          endcase
          // true value does not fit the lane, compares never trip this
          if (sign_ext(s[63:0] & mask, w) != s) cause[simd_types_pkg::CAUSE_OVF] = 1'b1;
          res = res | ((s[63:0] & mask) << (k * w));
        end
      end
    endcase
  endfunction

  function automatic simd_types_pkg::data_t select_src(
    input simd_types_pkg::data_t port_val,
    input logic [NUM_FWD-1:0]    now_sel,
    input logic [NUM_FWD-1:0]    prev_sel
  );
    for (int i = 0; i < NUM_FWD; i++) begin
      if (now_sel[i]) return fwd_bus[i];
      if (prev_sel[i]) return fwd_prev[i];
    end
    return port_val;
  endfunction

  // inputs are stable here, so they are the values the next edge takes
  always @(negedge clk) begin
    exp_t e;
    if (rst) begin
      exp_q.delete();
      en_pend = '0;
      en_last = '0;
    end else begin
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        e = exp_q.pop_front();
        checks++;
        raise_acc = raise_acc | e.cause;
        assert (result_valid === 1'b1 && result === e.res &&
                ret_code === (e.cause & en_last) && ret_valid === |(e.cause & en_last))
          else begin
            errors++;
            $display("FAIL %0t: got v=%b %h ret %b/%b, expected %h ret %b/%b", $time,
                     result_valid, result, ret_valid, ret_code, e.res,
                     |(e.cause & en_last), e.cause & en_last);
          end
      end else begin
        assert (result_valid === 1'b0)
          else begin
            errors++;
            $display("FAIL %0t: result_valid high with no result due", $time);
          end
      end
      en_last = en_pend;
      if (psel && penable && pwrite && paddr == simd_csr_pkg::CTRL_ADDR) begin
        en_pend = pwdata[simd_types_pkg::CAUSE_W-1:0];
      end
      if (issue_valid) begin
        model_exec(issue_op, issue_lane_sz, select_src(src_a, fwd_now_a, fwd_prev_a),
                   select_src(src_b, fwd_now_b, fwd_prev_b), e.res, e.cause);
        e.due = cyc + 2;
        exp_q.push_back(e);
      end
    end
    fwd_prev = fwd_bus;
  end

  function automatic simd_types_pkg::data_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // none, one current bus or one previous bus
  function automatic void rand_sel(output logic [NUM_FWD-1:0] now_sel,
                                   output logic [NUM_FWD-1:0] prev_sel);
    int r;
    r = $unsigned($random(seed)) % (2 * NUM_FWD + 1);
    now_sel = '0;
    prev_sel = '0;
    if (r >= 1 && r <= NUM_FWD) now_sel[r-1] = 1'b1;
    else if (r > NUM_FWD) prev_sel[r-NUM_FWD-1] = 1'b1;
  endfunction

  task automatic drive_cycle(input logic valid, input int op_lo, input int op_hi,
                             input bit use_fwd);
    logic [NUM_FWD-1:0] na;
    logic [NUM_FWD-1:0] pa;
    logic [NUM_FWD-1:0] nb;
    logic [NUM_FWD-1:0] pb;
    logic [1:0] lsz;
    simd_types_pkg::data_t a;
    simd_types_pkg::data_t b;
    int opc;
    fwd_t fb;
    a = rand_word();
    b = (($random(seed) & 3) == 0) ? a : rand_word(); // equal lanes now and then
    opc = op_lo + $unsigned($random(seed)) % (op_hi - op_lo + 1);
    lsz = $random(seed);
    for (int i = 0; i < NUM_FWD; i++) fb[i] = rand_word();
    na = '0;
    pa = '0;
    nb = '0;
    pb = '0;
    if (use_fwd) begin
      rand_sel(na, pa);
      rand_sel(nb, pb);
    end
    @(posedge clk);
    issue_valid <= valid;
    issue_op <= simd_types_pkg::opcode_e'(opc[2:0]);
    issue_lane_sz <= simd_types_pkg::lane_sz_e'(lsz);
    src_a <= a;
    src_b <= b;
    fwd_bus <= fb;
    fwd_now_a <= na;
    fwd_prev_a <= pa;
    fwd_now_b <= nb;
    fwd_prev_b <= pb;
  endtask

  task automatic issue_ops(input int count, input int op_lo, input int op_hi,
                           input bit use_fwd, input int max_gap);
    int gap;
    for (int n = 0; n < count; n++) begin
      gap = $unsigned($random(seed)) % (max_gap + 1);
      repeat (gap) drive_cycle(1'b0, op_lo, op_hi, use_fwd);
      drive_cycle(1'b1, op_lo, op_hi, use_fwd);
    end
    drive_cycle(1'b0, op_lo, op_hi, use_fwd);
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic apb_xfer(input logic wr, input simd_csr_pkg::apb_addr_t addr,
                          input simd_csr_pkg::apb_data_t wdata,
                          output simd_csr_pkg::apb_data_t rdata, output logic err);
    @(posedge clk);
    psel <= 1'b1;
    pwrite <= wr;
    paddr <= addr;
    pwdata <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (pready !== 1'b1) @(negedge clk);
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic check_reg(input string what, input simd_csr_pkg::apb_data_t got,
                           input simd_csr_pkg::apb_data_t exp, input logic err,
                           input logic exp_err);
    checks++;
    assert (got === exp && err === exp_err)
      else begin
        errors++;
        $display("FAIL %0t: %s got %h err %b, expected %h err %b", $time, what, got, err,
                 exp, exp_err);
      end
  endtask

  task automatic finish_test(input string name);
    test_no++;
    $display("test %0d %s: %0d checks, %0d errors", test_no, name, checks - checks_at,
             errors - errors_at);
    checks_at = checks;
    errors_at = errors;
  endtask

  initial begin
    simd_csr_pkg::apb_data_t rd;
    simd_csr_pkg::apb_data_t wd;
    logic err;
    clk = 1'b0;
    rst = 1'b1;
    issue_valid = 1'b0;
    issue_op = simd_types_pkg::op_add;
    issue_lane_sz = simd_types_pkg::lane_16;
    src_a = '0;
    src_b = '0;
    fwd_bus = '0;
    fwd_now_a = '0;
    fwd_prev_a = '0;
    fwd_now_b = '0;
    fwd_prev_b = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    apb_xfer(1'b1, simd_csr_pkg::CTRL_ADDR, 32'h3, rd, err); // all causes visible
    issue_ops(N_OPS, 0, 1, 1'b0, 0);
    drain();
    finish_test("add/sub wrap and overflow");

    issue_ops(N_OPS, 2, 7, 1'b0, 0);
    drain();
    finish_test("logic, compares, illegal");

    issue_ops(N_OPS, 0, 7, 1'b1, 0);
    drain();
    finish_test("operand forwarding");

    issue_ops(N_OPS, 0, 7, 1'b1, 3);
    drain();
    finish_test("back-to-back with gaps");

    for (int en = 0; en < 3; en++) begin
      apb_xfer(1'b1, simd_csr_pkg::CTRL_ADDR, en, rd, err);
      issue_ops(N_OPS / 4, 0, 7, 1'b0, 1);
      drain();
    end
    apb_xfer(1'b0, simd_csr_pkg::STATUS_ADDR, '0, rd, err);
    check_reg("STATUS sticky", rd, {30'd0, raise_acc}, err, 1'b0);
    apb_xfer(1'b1, simd_csr_pkg::STATUS_ADDR, 32'h3, rd, err);
    raise_acc = '0;
    apb_xfer(1'b0, simd_csr_pkg::STATUS_ADDR, '0, rd, err);
    check_reg("STATUS after clear", rd, '0, err, 1'b0);
    finish_test("exception enable and status");

    apb_xfer(1'b0, 8'h08, '0, rd, err);
    check_reg("unmapped read", rd, '0, err, 1'b1);
    apb_xfer(1'b1, 8'hfc, $random(seed), rd, err);
    check_reg("unmapped write", rd, '0, err, 1'b1);
    wd = $random(seed);
    apb_xfer(1'b1, simd_csr_pkg::CTRL_ADDR, wd, rd, err);
    apb_xfer(1'b0, simd_csr_pkg::CTRL_ADDR, '0, rd, err);
    check_reg("CTRL readback", rd, wd & 32'h3, err, 1'b0);
    finish_test("APB map");

    errors = errors + simd_exec_unit_i.props_i.fail_cnt;
    $display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
